//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = except_tb
FILELIST  = mips_except.f
OBJ_DIR   = obj_dir
PASS_TEXT = Result: PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_TEXT)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- design/cp0_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module cp0_regs (
	input  cpu_pkg::Bit_t       clk,
	input  cpu_pkg::Bit_t       rst,
	cp0_write_if.sink           wr,
	input  cpu_pkg::ExceptReq_t except_req,
	input  logic [5:0]          hw_int,
	input  cpu_pkg::RegAddr_t   raddr,
	output cpu_pkg::Word_t      rdata,
	output cpu_pkg::CP0Regs_t   regs
);

	cpu_pkg::Word_t    wr_mask;
	cpu_pkg::Word_t    wr_old;
	cpu_pkg::CP0Regs_t regs_q;
	cpu_pkg::CP0Regs_t regs_d;

	cp0_write_mask u_wr_mask (
		.rst  (rst),
		.sel  (wr.sel),
		.addr (wr.waddr),
		.mask (wr_mask)
	);

	always_comb begin
		regs_d = regs_q;

		// hardware lines land in ip[7:2], one cycle late
		regs_d.cause.ip[7:2] = hw_int;

		wr_old = regs_q[wr.waddr * `REG_DATA_WIDTH +: `REG_DATA_WIDTH];
		if (wr.we) begin
			regs_d[wr.waddr * `REG_DATA_WIDTH +: `REG_DATA_WIDTH] =
				(wr.wdata & wr_mask) | (wr_old & ~wr_mask);
		end

		// commit goes on top of the MTC0 write
		if (except_req.flush) begin
			if (except_req.eret) begin
				if (regs_d.status.erl) begin
					regs_d.status.erl = 1'b0;
				end else begin
					regs_d.status.exl = 1'b0;
				end
			end else begin
				// nested exception keeps the first EPC and bd
				if (!regs_d.status.exl) begin
					regs_d.epc      = except_req.delayslot ?
						except_req.cur_pc - 32'd4 : except_req.cur_pc;
					regs_d.cause.bd = except_req.delayslot;
				end
				regs_d.cause.exccode = except_req.code;
				regs_d.status.exl    = 1'b1;

				case (except_req.code)
					`EXCCODE_ADEL,
					`EXCCODE_ADES,
					`EXCCODE_TLBL,
					`EXCCODE_TLBS,
					`EXCCODE_MOD: regs_d.badvaddr = except_req.extra;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			regs_q            <= '0;
			// boot vectors, error level set
			regs_q.status.bev <= 1'b1;
			regs_q.status.erl <= 1'b1;
		end else begin
			regs_q <= regs_d;
		end
	end

	// MFC0 port
	assign rdata = regs_q[raddr * `REG_DATA_WIDTH +: `REG_DATA_WIDTH];

	assign regs = regs_q;

endmodule

`default_nettype wire

//--- design/cp0_write_if.sv
`timescale 1ns/10ps
`default_nettype none

// one MTC0 write from writeback, single-cycle strobe on we
interface cp0_write_if;

	cpu_pkg::Bit_t     we;
	cpu_pkg::RegAddr_t waddr;
	logic [2:0]        sel;
	cpu_pkg::Word_t    wdata;

	modport source (
		output we,
		output waddr,
		output sel,
		output wdata
	);

	modport sink (
		input we,
		input waddr,
		input sel,
		input wdata
	);

endinterface

`default_nettype wire

//--- design/cp0_write_mask.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module cp0_write_mask (
	input  cpu_pkg::Bit_t     rst,
	input  logic [2:0]        sel,
	input  cpu_pkg::RegAddr_t addr,
	output cpu_pkg::Word_t    mask
);

	cpu_pkg::Status_t status_mask;
	cpu_pkg::Cause_t  cause_mask;

	always_comb begin
		status_mask      = '0;
		status_mask.bev  = 1'b1;
		status_mask.im   = '1;
		status_mask.um   = 1'b1;
		status_mask.erl  = 1'b1;
		status_mask.exl  = 1'b1;
		status_mask.ie   = 1'b1;

		// only the two software interrupt bits of ip
		cause_mask         = '0;
		cause_mask.iv      = 1'b1;
		cause_mask.ip[1:0] = 2'b11;

		mask = `ZERO_WORD;
		if (!rst && sel == 3'd0) begin
			case (addr)
				`CP0_STATUS:                mask = status_mask;
				`CP0_CAUSE:                 mask = cause_mask;
				`CP0_BADVADDR:              mask = `ZERO_WORD;
				`CP0_EPC, `CP0_ERROR_EPC:   mask = '1;
				// unimplemented registers act as plain storage
				default:                    mask = '1;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// width of one CP0 register
`define REG_DATA_WIDTH 32
`define ZERO_WORD      32'h0000_0000

// MIPS32 Cause.ExcCode values
`define EXCCODE_INT  5'h00
`define EXCCODE_MOD  5'h01
`define EXCCODE_TLBL 5'h02
`define EXCCODE_TLBS 5'h03
`define EXCCODE_ADEL 5'h04
`define EXCCODE_ADES 5'h05
`define EXCCODE_SYS  5'h08
`define EXCCODE_BP   5'h09
`define EXCCODE_RI   5'h0a
`define EXCCODE_CpU  5'h0b
`define EXCCODE_OV   5'h0c
`define EXCCODE_TR   5'h0d

// CP0 register numbers, select 0
`define CP0_BADVADDR  5'd8
`define CP0_STATUS    5'd12
`define CP0_CAUSE     5'd13
`define CP0_EPC       5'd14
`define CP0_ERROR_EPC 5'd30

// exception vector bases, picked by Status.BEV
`define VEC_BASE_BOOT   32'hbfc0_0200
`define VEC_BASE_NORMAL 32'h8000_0000

// offsets added to the base
`define VEC_OFF_REFILL  16'h0000
`define VEC_OFF_GENERAL 16'h0180
`define VEC_OFF_INT     16'h0200

`endif

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic        Bit_t;
	typedef logic [15:0] HalfWord_t;
	typedef logic [31:0] Word_t;
	typedef logic [31:0] InstAddr_t;
	typedef logic [31:0] MemAddr_t;
	typedef logic [4:0]  RegAddr_t;
	typedef logic [4:0]  ExcCode_t;

	// Status, bit 31 first
	typedef struct packed {
		logic [8:0] rsv_31_23;
		Bit_t       bev;
		logic [5:0] rsv_21_16;
		logic [7:0] im;
		logic [2:0] rsv_7_5;
		Bit_t       um;
		Bit_t       rsv_3;
		Bit_t       erl;
		Bit_t       exl;
		Bit_t       ie;
	} Status_t;

	typedef struct packed {
		Bit_t       bd;
		logic [6:0] rsv_30_24;
		Bit_t       iv;
		logic [6:0] rsv_22_16;
		logic [7:0] ip;
		Bit_t       rsv_7;
		ExcCode_t   exccode;
		logic [1:0] rsv_1_0;
	} Cause_t;

	// register n sits at bits n*32 +: 32
	typedef struct packed {
		Word_t        rsv_31;
		Word_t        error_epc;
		Word_t [14:0] rsv_29_15;
		Word_t        epc;
		Cause_t       cause;
		Status_t      status;
		Word_t [2:0]  rsv_11_9;
		Word_t        badvaddr;
		Word_t [7:0]  rsv_7_0;
	} CP0Regs_t;

	typedef struct packed {
		InstAddr_t pc;
		Bit_t      delayslot;
	} PipelineData_t;

	// one bit per source, so two pipes merge with a bitwise or
	typedef struct packed {
		Bit_t iaddr_illegal;
		Bit_t iaddr_miss;
		Bit_t iaddr_invalid;
		Bit_t syscall;
		Bit_t break_;
		Bit_t overflow;
		Bit_t trap;
		Bit_t eret;
		Bit_t priv_inst;
		Bit_t invalid_inst;
		// unaligned or outside the mapped segment
		Bit_t daddr_illegal;
		Bit_t daddr_miss;
		Bit_t daddr_invalid;
		Bit_t daddr_readonly;
	} ExceptInfo_t;

	typedef struct packed {
		Bit_t      flush;
		Bit_t      alpha_taken;
		Bit_t      eret;
		Bit_t      delayslot;
		ExcCode_t  code;
		InstAddr_t cur_pc;
		InstAddr_t jump_pc;
		Word_t     extra;
	} ExceptReq_t;

endpackage

`default_nettype wire

//--- design/except.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module except (
	input  cpu_pkg::Bit_t          rst,
	input  cpu_pkg::PipelineData_t data_a,
	input  cpu_pkg::PipelineData_t data_b,
	input  cpu_pkg::ExceptInfo_t   except_a,
	input  cpu_pkg::ExceptInfo_t   except_b,
	input  cpu_pkg::CP0Regs_t      cp0_regs_unsafe,
	input  cpu_pkg::MemAddr_t      data_vaddr,
	input  cpu_pkg::Bit_t          memory_data_we,
	cp0_write_if.sink              wb_cp0_reg_wr,
	output cpu_pkg::ExceptReq_t    except_req
);

	cpu_pkg::Word_t       wr_mask;
	cpu_pkg::Word_t       wr_old;
	cpu_pkg::CP0Regs_t    cp0_view;
	cpu_pkg::ExceptInfo_t flags;
	cpu_pkg::Bit_t        user_mode;
	cpu_pkg::Bit_t        interrupt_occur;
	cpu_pkg::Bit_t        exc_valid;
	cpu_pkg::Bit_t        alpha_taken;
	cpu_pkg::Bit_t        sel_eret;
	cpu_pkg::Bit_t        sel_refill;
	cpu_pkg::Bit_t        sel_int;
	cpu_pkg::ExcCode_t    exc_code;
	cpu_pkg::Word_t       extra;
	cpu_pkg::InstAddr_t   sel_pc;
	cpu_pkg::Bit_t        sel_delayslot;
	cpu_pkg::HalfWord_t   vec_offset;
	cpu_pkg::InstAddr_t   vec_target;
	cpu_pkg::InstAddr_t   eret_target;

	cp0_write_mask u_wr_mask (
		.rst  (rst),
		.sel  (wb_cp0_reg_wr.sel),
		.addr (wb_cp0_reg_wr.waddr),
		.mask (wr_mask)
	);

	// MTC0 still in writeback, overlay it on the registered view
	always_comb begin
		cp0_view = cp0_regs_unsafe;
		wr_old   = cp0_regs_unsafe[wb_cp0_reg_wr.waddr * `REG_DATA_WIDTH +: `REG_DATA_WIDTH];
		if (wb_cp0_reg_wr.we) begin
			cp0_view[wb_cp0_reg_wr.waddr * `REG_DATA_WIDTH +: `REG_DATA_WIDTH] =
				(wb_cp0_reg_wr.wdata & wr_mask) | (wr_old & ~wr_mask);
		end
	end

	assign user_mode = cp0_view.status.um & ~cp0_view.status.exl & ~cp0_view.status.erl;

	assign interrupt_occur = cp0_view.status.ie & ~cp0_view.status.exl &
		~cp0_view.status.erl & (|(cp0_view.cause.ip & cp0_view.status.im));

	// architectural priority, pipe a first within a source
	always_comb begin
		flags           = except_a | except_b;
		flags.priv_inst = flags.priv_inst & user_mode;

		exc_valid   = 1'b1;
		exc_code    = `EXCCODE_INT;
		alpha_taken = 1'b0;
		extra       = `ZERO_WORD;
		sel_eret    = 1'b0;
		sel_refill  = 1'b0;
		sel_int     = 1'b0;

		if (interrupt_occur) begin
			alpha_taken = 1'b1;
			sel_int     = 1'b1;
		end else if (flags.iaddr_illegal) begin
			exc_code    = `EXCCODE_ADEL;
			alpha_taken = except_a.iaddr_illegal;
			extra       = alpha_taken ? data_a.pc : data_b.pc;
		end else if (flags.iaddr_miss) begin
			exc_code    = `EXCCODE_TLBL;
			alpha_taken = except_a.iaddr_miss;
			extra       = alpha_taken ? data_a.pc : data_b.pc;
			sel_refill  = 1'b1;
		end else if (flags.iaddr_invalid) begin
			exc_code    = `EXCCODE_TLBL;
			alpha_taken = except_a.iaddr_invalid;
			extra       = alpha_taken ? data_a.pc : data_b.pc;
		end else if (flags.syscall) begin
			exc_code    = `EXCCODE_SYS;
			alpha_taken = except_a.syscall;
		end else if (flags.break_) begin
			exc_code    = `EXCCODE_BP;
			alpha_taken = except_a.break_;
		end else if (flags.overflow) begin
			exc_code    = `EXCCODE_OV;
			alpha_taken = except_a.overflow;
		end else if (flags.trap) begin
			exc_code    = `EXCCODE_TR;
			alpha_taken = except_a.trap;
		end else if (flags.eret) begin
			// code stays 0 for ERET
			alpha_taken = except_a.eret;
			sel_eret    = 1'b1;
		end else if (flags.priv_inst) begin
			exc_code    = `EXCCODE_CpU;
			alpha_taken = except_a.priv_inst;
		end else if (flags.invalid_inst) begin
			exc_code    = `EXCCODE_RI;
			alpha_taken = except_a.invalid_inst;
		end else if (flags.daddr_illegal) begin
			exc_code    = memory_data_we ? `EXCCODE_ADES : `EXCCODE_ADEL;
			alpha_taken = except_a.daddr_illegal;
			extra       = data_vaddr;
		end else if (flags.daddr_miss) begin
			exc_code    = memory_data_we ? `EXCCODE_TLBS : `EXCCODE_TLBL;
			alpha_taken = except_a.daddr_miss;
			extra       = data_vaddr;
			sel_refill  = 1'b1;
		end else if (flags.daddr_invalid) begin
			exc_code    = memory_data_we ? `EXCCODE_TLBS : `EXCCODE_TLBL;
			alpha_taken = except_a.daddr_invalid;
			extra       = data_vaddr;
		end else if (flags.daddr_readonly) begin
			exc_code    = `EXCCODE_MOD;
			alpha_taken = except_a.daddr_readonly;
			extra       = data_vaddr;
		end else begin
			exc_valid = 1'b0;
		end
	end

	assign sel_pc        = alpha_taken ? data_a.pc : data_b.pc;
	assign sel_delayslot = alpha_taken ? data_a.delayslot : data_b.delayslot;

	// vector offset, refill and iv only apply with exl clear
	always_comb begin
		vec_offset = `VEC_OFF_GENERAL;
		if (!cp0_view.status.exl) begin
			if (sel_refill) begin
				vec_offset = `VEC_OFF_REFILL;
			end else if (sel_int && cp0_view.cause.iv) begin
				vec_offset = `VEC_OFF_INT;
			end
		end
	end

	assign vec_target = (cp0_view.status.bev ? `VEC_BASE_BOOT : `VEC_BASE_NORMAL) +
		{16'h0000, vec_offset};

	assign eret_target = cp0_view.status.erl ? cp0_view.error_epc : cp0_view.epc;

	always_comb begin
		except_req.alpha_taken = alpha_taken;
		except_req.extra       = extra;
		if (rst || !exc_valid) begin
			except_req.flush     = 1'b0;
			except_req.eret      = 1'b0;
			except_req.delayslot = 1'b0;
			except_req.code      = '0;
			except_req.cur_pc    = `ZERO_WORD;
			except_req.jump_pc   = `ZERO_WORD;
		end else begin
			except_req.flush     = 1'b1;
			except_req.eret      = sel_eret;
			except_req.delayslot = sel_delayslot;
			except_req.code      = exc_code;
			except_req.cur_pc    = sel_pc;
			except_req.jump_pc   = sel_eret ? eret_target : vec_target;
		end
	end

endmodule

`default_nettype wire

//--- design/except_top.sv
`timescale 1ns/10ps
`default_nettype none

module except_top (
	input  cpu_pkg::Bit_t        clk,
	input  cpu_pkg::Bit_t        rst,
	input  cpu_pkg::InstAddr_t   a_pc,
	input  cpu_pkg::Bit_t        a_delayslot,
	input  cpu_pkg::ExceptInfo_t a_except,
	input  cpu_pkg::InstAddr_t   b_pc,
	input  cpu_pkg::Bit_t        b_delayslot,
	input  cpu_pkg::ExceptInfo_t b_except,
	input  cpu_pkg::MemAddr_t    data_vaddr,
	input  cpu_pkg::Bit_t        memory_data_we,
	input  cpu_pkg::Bit_t        cp0_we,
	input  cpu_pkg::RegAddr_t    cp0_waddr,
	input  logic [2:0]           cp0_sel,
	input  cpu_pkg::Word_t       cp0_wdata,
	input  logic [5:0]           hw_int,
	input  cpu_pkg::RegAddr_t    cp0_raddr,
	output cpu_pkg::Word_t       cp0_rdata,
	output cpu_pkg::Bit_t        flush,
	output cpu_pkg::ExcCode_t    exc_code,
	output cpu_pkg::Bit_t        eret,
	output cpu_pkg::Bit_t        exc_delayslot,
	output cpu_pkg::InstAddr_t   cur_pc,
	output cpu_pkg::InstAddr_t   jump_pc
);

	cpu_pkg::PipelineData_t data_a;
	cpu_pkg::PipelineData_t data_b;
	cpu_pkg::ExceptReq_t    except_req;
	cpu_pkg::CP0Regs_t      cp0_regs_q;

	cp0_write_if wr_if ();

	// writeback MTC0 onto the shared write bus
	assign wr_if.we    = cp0_we;
	assign wr_if.waddr = cp0_waddr;
	assign wr_if.sel   = cp0_sel;
	assign wr_if.wdata = cp0_wdata;

	assign data_a = '{pc: a_pc, delayslot: a_delayslot};
	assign data_b = '{pc: b_pc, delayslot: b_delayslot};

	except u_except (
		.rst             (rst),
		.data_a          (data_a),
		.data_b          (data_b),
		.except_a        (a_except),
		.except_b        (b_except),
		.cp0_regs_unsafe (cp0_regs_q),
		.data_vaddr      (data_vaddr),
		.memory_data_we  (memory_data_we),
		.wb_cp0_reg_wr   (wr_if.sink),
		.except_req      (except_req)
	);

	cp0_regs u_cp0_regs (
		.clk        (clk),
		.rst        (rst),
		.wr         (wr_if.sink),
		.except_req (except_req),
		.hw_int     (hw_int),
		.raddr      (cp0_raddr),
		.rdata      (cp0_rdata),
		.regs       (cp0_regs_q)
	);

	assign flush         = except_req.flush;
	assign exc_code      = except_req.code;
	assign eret          = except_req.eret;
	assign exc_delayslot = except_req.delayslot;
	assign cur_pc        = except_req.cur_pc;
	assign jump_pc       = except_req.jump_pc;

endmodule

`default_nettype wire

//--- mips_except.f
+incdir+design
design/cpu_pkg.sv
design/cp0_write_if.sv
design/cp0_write_mask.sv
design/except.sv
design/cp0_regs.sv
design/except_top.sv
verification/except_assertions.sv
verification/except_tb.sv

//--- verification/except_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module except_assertions (
	input wire logic        clk,
	input wire logic        rst,
	input wire logic        flush,
	input wire logic        eret,
	input wire logic [4:0]  exc_code,
	input wire logic [31:0] jump_pc
);

	no_flush_in_reset: assert property (@(posedge clk) rst |-> !flush)
		else $error("flush raised while in reset");

	eret_needs_flush: assert property (@(posedge clk) disable iff (rst) eret |-> flush)
		else $error("eret without flush");

	code_idle_zero: assert property (@(posedge clk) !flush |-> exc_code == 5'd0)
		else $error("exception code set without flush");

	// vectors and EPC targets are always word addresses
	jump_aligned: assert property (@(posedge clk) flush |-> jump_pc[1:0] == 2'b00)
		else $error("jump target not word aligned");

endmodule

bind except_top except_assertions u_assertions (
	.clk      (clk),
	.rst      (rst),
	.flush    (flush),
	.eret     (eret),
	.exc_code (exc_code),
	.jump_pc  (jump_pc)
);

`default_nettype wire

//--- verification/except_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module except_tb;

	logic clk;
	logic rst;
	logic [31:0] a_pc;
	logic a_delayslot;
	cpu_pkg::ExceptInfo_t a_except;
	logic [31:0] b_pc;
	logic b_delayslot;
	cpu_pkg::ExceptInfo_t b_except;
	logic [31:0] data_vaddr;
	logic memory_data_we;
	logic cp0_we;
	logic [4:0] cp0_waddr;
	logic [2:0] cp0_sel;
	logic [31:0] cp0_wdata;
	logic [5:0] hw_int;
	logic [4:0] cp0_raddr;
	wire logic [31:0] cp0_rdata;
	wire logic flush;
	wire logic [4:0] exc_code;
	wire logic eret;
	wire logic exc_delayslot;
	wire logic [31:0] cur_pc;
	wire logic [31:0] jump_pc;

	// shadow CP0 state
	cpu_pkg::Status_t sh_status;
	cpu_pkg::Cause_t sh_cause;
	logic [31:0] sh_epc;
	logic [31:0] sh_error_epc;
	logic [31:0] sh_badvaddr;

	// status, cause, epc, error_epc, badvaddr as last read from the DUT
	logic [31:0] readback [5];

	logic [31:0] lfsr = 32'h8181af5e;
	logic last_flush;
	logic [4:0] last_code;
	logic [31:0] last_jump;
	int errors;
	int total_errors;
	int checks;
	int tests_run;
	int tests_failed;
	int i;

	except_top u_dut (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] writable_bits(input logic [4:0] addr, input logic [2:0] sel);
		if (sel != 3'd0)
			return 32'h0;
		case (addr)
			`CP0_STATUS:   return 32'h0040_ff17;
			`CP0_CAUSE:    return 32'h0080_0300;
			`CP0_BADVADDR: return 32'h0;
			default:       return 32'hffff_ffff;
		endcase
	endfunction

	// source index 14 is the interrupt, 13..0 follow the flag order
	function automatic logic [4:0] source_code(input int src);
		case (src)
			14: return `EXCCODE_INT;
			13: return `EXCCODE_ADEL;
			12, 11: return `EXCCODE_TLBL;
			10: return `EXCCODE_SYS;
			9: return `EXCCODE_BP;
			8: return `EXCCODE_OV;
			7: return `EXCCODE_TR;
			5: return `EXCCODE_CpU;
			4: return `EXCCODE_RI;
			3: return memory_data_we ? `EXCCODE_ADES : `EXCCODE_ADEL;
			2, 1: return memory_data_we ? `EXCCODE_TLBS : `EXCCODE_TLBL;
			0: return `EXCCODE_MOD;
			default: return 5'd0;
		endcase
	endfunction

	function automatic cpu_pkg::ExceptReq_t exp_request();
		cpu_pkg::ExceptReq_t r;
		cpu_pkg::Status_t st;
		cpu_pkg::Cause_t ca;
		logic [31:0] epc_v;
		logic [31:0] eepc_v;
		logic [31:0] m;
		logic [13:0] ea;
		logic [13:0] merged;
		logic [31:0] off;
		logic on_a;
		int src;
		int k;
		st = sh_status;
		ca = sh_cause;
		epc_v = sh_epc;
		eepc_v = sh_error_epc;
		m = writable_bits(cp0_waddr, cp0_sel);
		// pending MTC0 is already visible
		if (cp0_we) begin
			case (cp0_waddr)
				`CP0_STATUS:    st = (cp0_wdata & m) | (st & ~m);
				`CP0_CAUSE:     ca = (cp0_wdata & m) | (ca & ~m);
				`CP0_EPC:       epc_v = cp0_wdata;
				`CP0_ERROR_EPC: eepc_v = cp0_wdata;
				default: ;
			endcase
		end
		ea = a_except;
		merged = a_except | b_except;
		if (!(st.um && !st.exl && !st.erl))
			merged[5] = 1'b0;
		r = '0;
		src = -1;
		if (st.ie && !st.exl && !st.erl && (ca.ip & st.im) != 8'h0)
			src = 14;
		for (k = 13; k >= 0; k--)
			if (src < 0 && merged[k])
				src = k;
		if (src < 0 || rst)
			return r;
		on_a = (src == 14) ? 1'b1 : ea[src];
		r.flush = 1'b1;
		r.alpha_taken = on_a;
		r.cur_pc = on_a ? a_pc : b_pc;
		r.delayslot = on_a ? a_delayslot : b_delayslot;
		r.code = source_code(src);
		if (src >= 11 && src <= 13)
			r.extra = r.cur_pc;
		if (src <= 3)
			r.extra = data_vaddr;
		if (src == 6) begin
			r.eret = 1'b1;
			r.jump_pc = st.erl ? eepc_v : epc_v;
		end else begin
			off = 32'h0000_0180;
			if (!st.exl && (src == 12 || src == 2))
				off = 32'h0000_0000;
			else if (!st.exl && src == 14 && ca.iv)
				off = 32'h0000_0200;
			r.jump_pc = (st.bev ? 32'hbfc0_0200 : 32'h8000_0000) + off;
		end
		return r;
	endfunction

	task automatic update_shadow(input cpu_pkg::ExceptReq_t req);
		logic [31:0] m;
		cpu_pkg::Cause_t old_cause;
		m = writable_bits(cp0_waddr, cp0_sel);
		old_cause = sh_cause;
		sh_cause.ip[7:2] = hw_int;
		if (cp0_we) begin
			case (cp0_waddr)
				`CP0_STATUS:    sh_status = (cp0_wdata & m) | (sh_status & ~m);
				// the write keeps the old sampled ip bits
				`CP0_CAUSE:     sh_cause = (cp0_wdata & m) | (old_cause & ~m);
				`CP0_EPC:       sh_epc = cp0_wdata;
				`CP0_ERROR_EPC: sh_error_epc = cp0_wdata;
				default: ;
			endcase
		end
		if (req.flush && req.eret) begin
			if (sh_status.erl)
				sh_status.erl = 1'b0;
			else
				sh_status.exl = 1'b0;
		end else if (req.flush) begin
			if (!sh_status.exl) begin
				sh_epc = req.delayslot ? req.cur_pc - 32'd4 : req.cur_pc;
				sh_cause.bd = req.delayslot;
			end
			sh_cause.exccode = req.code;
			sh_status.exl = 1'b1;
			if (req.code inside {`EXCCODE_ADEL, `EXCCODE_ADES, `EXCCODE_TLBL,
					`EXCCODE_TLBS, `EXCCODE_MOD})
				sh_badvaddr = req.extra;
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_readback();
		logic [4:0] addrs [5];
		logic [31:0] exps [5];
		int k;
		addrs = '{`CP0_STATUS, `CP0_CAUSE, `CP0_EPC, `CP0_ERROR_EPC, `CP0_BADVADDR};
		exps = '{sh_status, sh_cause, sh_epc, sh_error_epc, sh_badvaddr};
		for (k = 0; k < 5; k++) begin
			cp0_raddr = addrs[k];
			#0.2;
			readback[k] = cp0_rdata;
			check_word($sformatf("cp0 reg %0d", addrs[k]), cp0_rdata, exps[k]);
		end
	endtask

	// entered 2 ns after an edge with the inputs driven, leaves 2 ns after the next
	task automatic step();
		cpu_pkg::ExceptReq_t req;
		#8;
		req = exp_request();
		check_word("flush", 32'(flush), 32'(req.flush));
		check_word("exc_code", 32'(exc_code), 32'(req.code));
		check_word("eret", 32'(eret), 32'(req.eret));
		check_word("exc_delayslot", 32'(exc_delayslot), 32'(req.delayslot));
		check_word("cur_pc", cur_pc, req.cur_pc);
		check_word("jump_pc", jump_pc, req.jump_pc);
		last_flush = flush;
		last_code = exc_code;
		last_jump = jump_pc;
		@(posedge clk);
		update_shadow(req);
		#1;
		check_readback();
		cp0_we = 1'b0;
		a_except = '0;
		b_except = '0;
	endtask

	task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
		cp0_we = 1'b1;
		cp0_waddr = addr;
		cp0_sel = 3'd0;
		cp0_wdata = data;
	endtask

	task automatic wait_flush(input int max_cycles);
		int n;
		n = 0;
		last_flush = 1'b0;
		while (!last_flush && n < max_cycles) begin
			step();
			n++;
		end
		if (!last_flush) begin
			$display("timeout at %0t: no flush within %0d cycles", $time, max_cycles);
			errors++;
		end
	endtask

	task automatic begin_test();
		errors = 0;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s, %0d errors", tests_run, name, errors == 0 ? "ok" : "bad", errors);
		total_errors += errors;
		if (errors != 0)
			tests_failed++;
	endtask

	initial begin
		rst = 1'b1;
		{a_pc, a_delayslot, b_pc, b_delayslot, data_vaddr, memory_data_we} = '0;
		a_except = '0;
		b_except = '0;
		{cp0_we, cp0_waddr, cp0_sel, cp0_wdata, hw_int, cp0_raddr} = '0;
		{total_errors, checks, tests_run, tests_failed} = '0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		sh_status = 32'h0040_0004;
		{sh_cause, sh_epc, sh_error_epc, sh_badvaddr} = '0;

		begin_test();
		for (i = 0; i < 60; i++) begin
			write_cp0(`CP0_STATUS, {9'h0, rand_bits(1) == 1, 17'h0, rand_bits(1) == 1, 4'h0});
			step();
			a_except = 14'(rand_bits(14) & rand_bits(14) & rand_bits(14));
			b_except = 14'(rand_bits(14) & rand_bits(14) & rand_bits(14));
			a_pc = {30'(rand_bits(30)), 2'b00};
			b_pc = {30'(rand_bits(30)), 2'b00};
			a_delayslot = rand_bits(1) == 1;
			b_delayslot = rand_bits(1) == 1;
			data_vaddr = rand_bits(32);
			memory_data_we = rand_bits(1) == 1;
			step();
		end
		end_test("random flags");

		begin_test();
		write_cp0(`CP0_STATUS, 32'h0);
		step();
		b_except.syscall = 1'b1;
		b_pc = 32'h1000_0010;
		b_delayslot = 1'b1;
		step();
		check_word("epc after delay slot", readback[2], 32'h1000_000c);
		// second exception while exl is still set
		a_except.daddr_illegal = 1'b1;
		data_vaddr = 32'h0000_1233;
		step();
		check_word("nested jump_pc", last_jump, 32'h8000_0180);
		check_word("epc kept", readback[2], 32'h1000_000c);
		end_test("commit");

		begin_test();
		write_cp0(`CP0_STATUS, 32'h0000_fc01);
		step();
		hw_int = 6'h04;
		wait_flush(4);
		check_word("interrupt code", 32'(last_code), 32'(`EXCCODE_INT));
		write_cp0(`CP0_CAUSE, 32'h0080_0000);
		step();
		write_cp0(`CP0_STATUS, 32'h0000_fc01);
		step();
		write_cp0(`CP0_STATUS, 32'h0000_fc00);
		step();
		check_word("flush with ie clear", 32'(last_flush), 32'd0);
		hw_int = 6'h00;
		step();
		end_test("interrupts");

		begin_test();
		write_cp0(`CP0_EPC, 32'h8000_1230);
		step();
		write_cp0(`CP0_ERROR_EPC, 32'h8000_2000);
		step();
		write_cp0(`CP0_STATUS, 32'h0000_0002);
		step();
		a_except.eret = 1'b1;
		step();
		write_cp0(`CP0_STATUS, 32'h0000_0006);
		step();
		b_except.eret = 1'b1;
		step();
		end_test("eret");

		begin_test();
		write_cp0(`CP0_STATUS, 32'hffff_ffff);
		step();
		check_word("status mask", readback[0], 32'h0040_ff17);
		write_cp0(`CP0_CAUSE, 32'hffff_ffff);
		step();
		write_cp0(`CP0_CAUSE, 32'h0);
		step();
		// BEV write and exception in one cycle
		write_cp0(`CP0_STATUS, 32'h0040_0000);
		a_except.syscall = 1'b1;
		a_pc = 32'h0000_0400;
		a_delayslot = 1'b0;
		step();
		check_word("boot vector", last_jump, 32'hbfc0_0380);
		end_test("mtc0 masks");

		begin_test();
		write_cp0(`CP0_STATUS, 32'h0000_0010);
		b_except.priv_inst = 1'b1;
		step();
		check_word("user mode CpU", 32'(last_code), 32'(`EXCCODE_CpU));
		write_cp0(`CP0_STATUS, 32'h0000_0000);
		a_except.priv_inst = 1'b1;
		step();
		check_word("kernel priv_inst", 32'(last_flush), 32'd0);
		end_test("priv_inst");

		$display("tests: %0d run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, total_errors);
		if (total_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
